// File: design/audio_rx_pkg.sv
package audio_rx_pkg;

   localparam int SAMPLE_W        = 8;    // width of one audio sample
   localparam int GAIN_W          = 4;    // width of the volume control in eighths
   localparam int SCLK_HALF       = 4;    // clk cycles per half period of sclk
   localparam int MIDSCALE        = 128;  // silence level of the offset-binary code
   localparam int SAMPLE_MAX      = 255;  // upper saturation bound of a sample
   localparam int BITS_PER_SAMPLE = 8;    // serial bits that make up one sample
   localparam int PWM_W           = 8;    // pwm counter width, period is 2**PWM_W clk
   localparam int GAIN_SHIFT      = 3;    // gain is in eighths so unity is 1 << 3

   localparam int HALF_CNT_W = $clog2(SCLK_HALF);          // counts 0 .. SCLK_HALF-1
   localparam int BIT_CNT_W  = $clog2(BITS_PER_SAMPLE + 1); // counts 0 .. BITS_PER_SAMPLE

   typedef logic [SAMPLE_W-1:0]   sample_t;      // offset binary, 128 is silence
   typedef logic [GAIN_W-1:0]     gain_t;        // 0 .. 15 eighths, 8 is unity
   typedef logic [HALF_CNT_W-1:0] half_count_t;  // position inside one sclk half period
   typedef logic [BIT_CNT_W-1:0]  bit_count_t;   // bits collected for the current sample
   typedef logic [PWM_W-1:0]      pwm_count_t;   // position inside one pwm period

   // signed deviation from midscale, one bit wider than a sample
   typedef logic signed [SAMPLE_W:0] deviation_t;

   // deviation times gain, wide enough for -128 * 15 plus the midscale offset
   typedef logic signed [SAMPLE_W+GAIN_W:0] product_t;

   // one sample moving between stages, valid is a single clk pulse
   typedef struct packed {
      sample_t sample;  // audio value in offset binary
      logic    valid;   // high for one clk when sample is new
   } sample_beat_t;

endpackage

// File: design/sclk_divider.sv
module sclk_divider
   import audio_rx_pkg::*;
(
   input  logic clk,
   input  logic rst,
   output logic sclk,       // serial clock to the microcontroller
   output logic bit_strobe  // one clk pulse after each falling edge of sclk
);

   half_count_t half_count;  // clk cycles spent in the current sclk level
   logic        sclk_prev;   // sclk delayed by one clk for edge detection

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         half_count <= '0;  // start of the first low half
         sclk       <= 1'b0;  // sclk idles low so the first edge is a rise
      end else begin
         if (half_count == half_count_t'(SCLK_HALF - 1)) begin
            half_count <= '0;  // half period done, start counting the next one
            sclk       <= ~sclk;  // flip the serial clock level
         end else begin
            half_count <= half_count + 1'b1;  // still inside this half period
         end
      end
   end

   // the edge detector register that trails sclk by one clk
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sclk_prev <= 1'b0;  // matches sclk so no false edge comes out of reset
      end else begin
         sclk_prev <= sclk;  // previous level for the falling edge test
      end
   end

   // high only in the single cycle where sclk is already low but sclk_prev is still high
   assign bit_strobe = sclk_prev & ~sclk;

   // strobes are spaced a full sclk period apart, never back to back
   a_strobe_single : assert property (
      @(posedge clk) disable iff (rst) bit_strobe |=> !bit_strobe
   );

endmodule

// File: design/serial_deserializer.sv
module serial_deserializer
   import audio_rx_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         bit_strobe,  // sample serial_in on this clk
   input  logic         serial_in,   // data from the microcontroller, msb first
   output sample_beat_t raw_beat     // completed sample with a one clk valid
);

   sample_t    shift_reg;  // bits of the sample being collected, newest in the lsb
   bit_count_t bit_count;  // bits already held in shift_reg, 0 only after reset
   logic       buf_full;   // shift_reg holds a complete sample

   assign buf_full = (bit_count == bit_count_t'(BITS_PER_SAMPLE));

   // msb arrives first, so each new bit pushes the older ones to the left
   always_ff @(posedge clk) begin
      if (bit_strobe) begin
         shift_reg <= {shift_reg[SAMPLE_W-2:0], serial_in};
      end
   end

   // the counter restarts at 1 because the strobe that empties the buffer
   // also brings in the first bit of the next sample
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bit_count <= '0;  // bit alignment is counted from reset
      end else if (bit_strobe) begin
         if (buf_full) begin
            bit_count <= bit_count_t'(1);  // new bit starts the next sample
         end else begin
            bit_count <= bit_count + 1'b1;  // one more bit of this sample
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         raw_beat.sample <= sample_t'(MIDSCALE);  // silence until the first sample lands
         raw_beat.valid  <= 1'b0;
      end else begin
         raw_beat.valid <= bit_strobe & buf_full;  // pulse, not a level
         if (bit_strobe && buf_full) begin
            raw_beat.sample <= shift_reg;  // hand over the buffer before the shift lands
         end
      end
   end

   // a sample can only be completed by a strobe one cycle earlier
   a_valid_after_strobe : assert property (
      @(posedge clk) disable iff (rst) raw_beat.valid |-> $past(bit_strobe)
   );

endmodule

// File: design/volume_scaler.sv
module volume_scaler
   import audio_rx_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  gain_t        volume,      // gain in eighths, sampled with the beat
   input  sample_beat_t raw_beat,    // sample from the deserializer
   output sample_beat_t scaled_beat  // scaled sample, one clk later
);

   deviation_t deviation;  // signed distance of the input from silence
   product_t   product;    // deviation times gain, still in eighths
   product_t   shifted;    // product divided by 8, rounding toward minus infinity
   product_t   level;      // back in offset binary but not yet clamped
   sample_t    clamped;    // level forced into 0 .. SAMPLE_MAX

   always_comb begin
      // zero extend the sample so 255 stays positive before taking off the offset
      deviation = deviation_t'({1'b0, raw_beat.sample}) - deviation_t'(MIDSCALE);

      // volume is zero extended so the multiply stays signed
      product = product_t'(deviation) * product_t'({1'b0, volume});
      shifted = product >>> GAIN_SHIFT;  // arithmetic shift keeps the sign
      level   = shifted + product_t'(MIDSCALE);

      if (level < 0) begin
         clamped = '0;  // too loud on the negative side
      end else if (level > product_t'(SAMPLE_MAX)) begin
         clamped = sample_t'(SAMPLE_MAX);  // too loud on the positive side
      end else begin
         clamped = sample_t'(level);  // in range, drop the sign bits
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         scaled_beat.sample <= sample_t'(MIDSCALE);  // silence out of reset
         scaled_beat.valid  <= 1'b0;
      end else begin
         scaled_beat.valid <= raw_beat.valid;  // one clk copy of the input pulse
         if (raw_beat.valid) begin
            scaled_beat.sample <= clamped;  // gain is taken in this same cycle
         end
      end
   end

   // downstream may read the sample at any time, so it only moves with a pulse
   a_hold_between_beats : assert property (
      @(posedge clk) disable iff (rst) !scaled_beat.valid |-> $stable(scaled_beat.sample)
   );

endmodule

// File: design/pwm_dac.sv
module pwm_dac
   import audio_rx_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  sample_beat_t scaled_beat,  // new duty arrives with valid
   output logic         pwm_out       // to the external rc filter
);

   pwm_count_t count;         // free running position in the 256 clk period
   sample_t    pending_duty;  // latest sample, waits for the period to end
   sample_t    active_duty;   // duty used for the current period
   logic       period_end;    // last cycle of the period, count is about to wrap

   assign period_end = (count == '1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;  // period starts right after reset
      end else begin
         count <= count + 1'b1;  // wraps to 0 by itself every 256 clk
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending_duty <= sample_t'(MIDSCALE);  // half duty, the filter sits at midscale
         active_duty  <= sample_t'(MIDSCALE);
      end else begin
         if (scaled_beat.valid) begin
            pending_duty <= scaled_beat.sample;  // a newer beat simply overwrites it
         end
         if (period_end) begin
            active_duty <= pending_duty;  // switch only at the wrap so no period is cut
         end
      end
   end

   // the compare is strict, so a duty of 0 keeps the output low all period
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pwm_out <= 1'b0;
      end else begin
         pwm_out <= (count < active_duty);
      end
   end

endmodule

// File: design/audio_rx_top.sv
module audio_rx_top
   import audio_rx_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         serial_in,  // serial data from the microcontroller
   input  gain_t        volume,     // quasi static gain setting
   output logic         sclk,       // serial clock we supply to the microcontroller
   output sample_beat_t audio_out,  // scaled samples, valid 2 clk after the strobe
   output logic         pwm_out     // pwm output to the rc filter
);

   logic         bit_strobe;   // one clk after each falling sclk edge
   sample_beat_t raw_beat;     // deserialized sample, before the gain
   sample_beat_t scaled_beat;  // sample after gain and saturation

   sclk_divider u_sclk_divider (
      .clk        (clk),
      .rst        (rst),
      .sclk       (sclk),
      .bit_strobe (bit_strobe)
   );

   serial_deserializer u_serial_deserializer (
      .clk        (clk),
      .rst        (rst),
      .bit_strobe (bit_strobe),
      .serial_in  (serial_in),
      .raw_beat   (raw_beat)
   );

   volume_scaler u_volume_scaler (
      .clk         (clk),
      .rst         (rst),
      .volume      (volume),
      .raw_beat    (raw_beat),
      .scaled_beat (scaled_beat)
   );

   pwm_dac u_pwm_dac (
      .clk         (clk),
      .rst         (rst),
      .scaled_beat (scaled_beat),
      .pwm_out     (pwm_out)
   );

   assign audio_out = scaled_beat;  // the same beat also feeds the pwm stage

endmodule

// File: verif/audio_rx_tb.sv
module audio_rx_tb;
   import audio_rx_pkg::*;

   localparam int CLK_HALF    = 20;   // 40 time unit clk period
   localparam int RESET_CYC   = 8;    // clk cycles with rst held high
   localparam int ROWS        = 12;   // rows in the stimulus table
   localparam int BITS        = 8;    // serial bits per sample, msb first
   localparam int HALF_CLKS   = 4;    // clk cycles per sclk level
   localparam int PWM_PERIOD  = 256;  // clk cycles per pwm period
   localparam int PWM_TESTS   = 3;    // duty values held after the table
   localparam int RUN_CYCLES  = ROWS * 64 + 80 + PWM_TESTS * 3 * PWM_PERIOD;
   localparam int CYCLE_LIMIT = 2 * RUN_CYCLES;  // run is stopped here if still busy

   logic         clk;
   logic         rst;
   logic         serial_in;  // driven by the source model below
   gain_t        volume;
   logic         sclk;
   sample_beat_t audio_out;
   logic         pwm_out;

   int tab_sample [ROWS];  // byte sent on the serial line
   int tab_gain   [ROWS];  // volume applied while the scaler takes that byte
   int tab_expect [ROWS];  // predicted audio_out sample
   int pwm_vals   [PWM_TESTS];  // bytes streamed at unity gain for the duty checks

   logic bit_q  [$];  // bits still to be shifted out by the source model
   int   exp_q  [$];  // predicted samples in the order they reach audio_out
   int   gain_q [$];  // gains for the samples after the one being scaled

   int   cyc;              // posedges since reset was released
   int   error_count;
   int   check_count;
   int   beats_seen;       // valid pulses seen on audio_out
   int   fall_count;       // falling sclk edges since reset
   logic sclk_seen;        // sclk as sampled on the previous falling clk edge
   logic valid_d1;         // completing strobe seen one cycle ago
   logic valid_d2;         // completing strobe seen two cycles ago
   int   hold_byte;        // byte repeated once the table is exhausted
   int   pwm_idx;          // current entry of pwm_vals
   int   pend_exp;         // predicted pending duty of the pwm stage
   int   last_change_cyc;  // cycle where pend_exp last took a new value
   logic win_armed;        // the current pwm period is being measured
   int   win_duty;         // duty expected over the current pwm period
   int   win_high;         // high cycles counted so far in it
   int   seed_val;

   audio_rx_top dut (
      .clk       (clk),
      .rst       (rst),
      .serial_in (serial_in),
      .volume    (volume),
      .sclk      (sclk),
      .audio_out (audio_out),
      .pwm_out   (pwm_out)
   );

   always #CLK_HALF clk = ~clk;

   // scaler rule worked out with floor division, then clamped into a byte
   function automatic int scale_sample(input int sample, input int gain);
      int prod;
      int floored;
      int level;
      prod = (sample - 128) * gain;  // deviation from silence, still in eighths
      if (prod >= 0) begin
         floored = prod / 8;
      end else begin
         floored = -((-prod + 7) / 8);  // rounds toward minus infinity
      end
      level = floored + 128;
      if (level < 0) begin
         return 0;
      end
      if (level > 255) begin
         return 255;
      end
      return level;
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      check_count++;
      assert (actual == expected) else begin
         error_count++;
         $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   // queues one byte msb first together with what audio_out should show for it
   task automatic push_byte(input int value, input int gain, input int expected);
      for (int i = BITS - 1; i >= 0; i--) begin
         bit_q.push_back(value[i]);
      end
      exp_q.push_back(expected);
      gain_q.push_back(gain);
   endtask

   task automatic build_table();
      tab_sample = '{90, 0, 0, 255, 1, 254, 0, 0, 255, 0, 0, 0};
      tab_gain   = '{8, 8, 15, 15, 12, 12, 3, 3, 0, 0, 8, 0};
      tab_sample[1]  = $urandom_range(255, 0);  // unity rows besides the fixed one
      tab_sample[10] = $urandom_range(255, 0);
      tab_sample[6]  = $urandom_range(255, 0);  // quiet gain on a random level
      tab_sample[9]  = $urandom_range(255, 0);  // gain 0 must still give silence
      tab_sample[11] = $urandom_range(255, 0);
      tab_gain[11]   = $urandom_range(15, 0);
      for (int i = 0; i < ROWS; i++) begin
         tab_expect[i] = scale_sample(tab_sample[i], tab_gain[i]);
      end
      pwm_vals = '{0, 200, 0};
      pwm_vals[2] = $urandom_range(254, 1);  // any duty strictly inside the period
   endtask

   // one falling clk edge: drive the inputs and look at everything the DUT shows
   task automatic watch_cycle();
      logic completing;
      int   exp_sample;
      @(negedge clk);
      cyc++;
      check_value("sclk", (cyc / HALF_CLKS) % 2, int'(sclk));  // low first, then every 4 clk

      // the microcontroller moves to the next bit once sclk has risen
      if (sclk && !sclk_seen) begin
         if (bit_q.size() == 0) begin
            push_byte(hold_byte, 8, scale_sample(hold_byte, 8));
         end
         serial_in = bit_q.pop_front();
      end

      // a falling sclk edge is a strobe, every 8th from the 9th on completes a sample
      completing = 1'b0;
      if (!sclk && sclk_seen) begin
         fall_count++;
         completing = (fall_count > BITS) && ((fall_count - 1) % BITS == 0);
      end
      sclk_seen = sclk;

      check_value("audio_out.valid", int'(valid_d2), int'(audio_out.valid));
      valid_d2 = valid_d1;  // audio_out answers 2 clk after the strobe
      valid_d1 = completing;

      if (win_armed && pwm_out) begin
         win_high++;
      end
      if (cyc % PWM_PERIOD == 0) begin
         if (win_armed) begin
            check_value("pwm_out", win_duty, win_high);  // high cycles in one period
            if (beats_seen >= ROWS && pwm_idx < PWM_TESTS && win_duty == pwm_vals[pwm_idx]) begin
               pwm_idx++;  // this duty has been seen over a whole period
            end
         end
         // a duty that changed right at the wrap may or may not make this period
         win_armed = (cyc - last_change_cyc >= 4);
         win_duty  = pend_exp;
         win_high  = 0;
      end

      if (audio_out.valid) begin
         check_count++;
         assert (exp_q.size() > 0) else begin
            error_count++;
            $display("Error at %0t: audio_out gave a beat that was never sent", $time);
         end
         if (exp_q.size() > 0) begin
            exp_sample = exp_q.pop_front();
            check_value("audio_out.sample", exp_sample, int'(audio_out.sample));
            if (exp_sample != pend_exp) begin
               pend_exp        = exp_sample;  // the pwm stage takes every beat
               last_change_cyc = cyc;
            end
            beats_seen++;
            // the next sample is scaled with its own gain
            if (gain_q.size() > 0) begin
               volume = gain_t'(gain_q.pop_front());
            end else begin
               volume = gain_t'(8);
            end
         end
      end
   endtask

   initial begin
      clk             = 1'b0;
      rst             = 1'b1;
      serial_in       = 1'b0;
      volume          = gain_t'(8);
      cyc             = 0;
      error_count     = 0;
      check_count     = 0;
      beats_seen      = 0;
      fall_count      = 0;
      sclk_seen       = 1'b0;
      valid_d1        = 1'b0;
      valid_d2        = 1'b0;
      pwm_idx         = 0;
      pend_exp        = 128;  // pwm duty out of reset
      last_change_cyc = -1000;
      win_armed       = 1'b0;
      win_duty        = 0;
      win_high        = 0;

      seed_val = $urandom(32'h5c9e);
      build_table();
      hold_byte = pwm_vals[0];

      // the whole table goes out back to back, row 0 first
      for (int i = 0; i < ROWS; i++) begin
         push_byte(tab_sample[i], tab_gain[i], tab_expect[i]);
      end
      volume = gain_t'(gain_q.pop_front());  // gain of row 0

      repeat (RESET_CYC) @(negedge clk);
      rst = 1'b0;
      check_value("sclk", 0, int'(sclk));
      check_value("audio_out.valid", 0, int'(audio_out.valid));
      check_value("audio_out.sample", 128, int'(audio_out.sample));
      win_armed = 1'b1;  // the first pwm period runs at midscale
      win_duty  = 128;

      while (pwm_idx < PWM_TESTS && cyc < CYCLE_LIMIT) begin
         watch_cycle();
         if (pwm_idx < PWM_TESTS) begin
            hold_byte = pwm_vals[pwm_idx];
         end
      end

      if (pwm_idx < PWM_TESTS) begin
         error_count++;
         $display("Timeout: stopped after %0d cycles with %0d beats seen and %0d duty tests done",
                  cyc, beats_seen, pwm_idx);
      end

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: build.f
design/audio_rx_pkg.sv
design/sclk_divider.sv
design/serial_deserializer.sv
design/volume_scaler.sv
design/pwm_dac.sv
design/audio_rx_top.sv
verif/audio_rx_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module audio_rx_tb -f build.f -o audio_rx_sim

status=0
./obj_dir/audio_rx_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
exit 0
